// ==== filelist.f ====
source/ifu_pkg.sv
source/ifu_ifs.sv
source/ifu_fetch_ctl.sv
source/ifu_icache.sv
source/ifu_bus_arb.sv
source/ifu_aligner.sv
source/ifu_top.sv
testbench/ifu_checker.sv
testbench/tb_ifu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
   --top-module tb_ifu -o sim_ifu
out=$(obj_dir/sim_ifu)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED"

// ==== source/ifu_aligner.sv ====
/*
 * instruction aligner
 * three-halfword buffer, forms 16-bit and 32-bit instructions
 * with pc and pc4 for decode, one per cycle
 */
`default_nettype none

module ifu_aligner import ifu_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,        // empties the buffer
   input  logic       instr_ready,  // decode takes instr
   ifu_word_if.sink   word_link,
   output logic       instr_valid,
   output instr_t     instr,
   output pc_t        instr_pc,
   output logic       instr_pc4
);

   logic [2:0][15:0] hw_q;      // [0] is the oldest halfword
   logic [1:0]       count_q;   // halfwords held, 0..3
   pc_t              head_pc;   // pc of hw_q[0]
   logic             ack_q;

   half_t            head;
   logic             is_full;   // head parcel is 32-bit
   logic             avail;     // complete instruction in buffer
   logic             consume;
   logic             accept;    // take the offered word
   logic             odd;       // word pc points at the high half
   logic [1:0]       take;
   logic [1:0]       cnt_mid;
   logic [1:0]       cnt_nxt;
   logic [2:0][15:0] hw_nxt;
   pc_t              pc_mid;

   assign head    = hw_q[0];
   assign is_full = (head[1:0] == length_code_full);
   assign avail   = (count_q != 2'd0) & (~is_full | (count_q >= 2'd2));

   assign instr_valid = avail & ~flush;        // old path never accepted on flush
   assign instr       = is_full ? {hw_q[1], hw_q[0]} : {16'h0000, hw_q[0]};
   assign instr_pc    = head_pc;
   assign instr_pc4   = is_full;

   assign consume = instr_valid & instr_ready;
   assign accept  = word_link.req & ~ack_q & ~flush & (count_q <= 2'd1);
   assign odd     = word_link.pc[1];
   assign word_link.ack = ack_q;

   // shift out consumed parcels then append the new word
   always_comb begin
      take = 2'd0;
      if (consume) take = is_full ? 2'd2 : 2'd1;
      cnt_mid = count_q - take;
      pc_mid  = head_pc;
      if (consume) pc_mid = head_pc + (is_full ? pc_step_full : pc_step_half);
      hw_nxt  = hw_q >> (16 * take);
      cnt_nxt = cnt_mid;
      if (accept) begin
         if (odd) begin                             // skip the low half
            hw_nxt[cnt_mid] = word_link.word[31:16];
            cnt_nxt         = cnt_mid + 2'd1;
         end else begin
            hw_nxt[cnt_mid]          = word_link.word[15:0];
            hw_nxt[2'(cnt_mid + 1)]  = word_link.word[31:16];
            cnt_nxt                  = cnt_mid + 2'd2;
         end
         if (cnt_mid == 2'd0) pc_mid = word_link.pc; // empty buffer restarts at word pc
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         count_q <= 2'd0;
         ack_q   <= 1'b0;
      end else begin
         if (accept) ack_q <= 1'b1;
         else if (ack_q & ~word_link.req) ack_q <= 1'b0; // close four-phase
         count_q <= flush ? 2'd0 : cnt_nxt;
      end
   end

   // buffer contents and head pc
   always_ff @(posedge clk) begin
      hw_q    <= hw_nxt;
      head_pc <= pc_mid;
   end

endmodule

`default_nettype wire

// ==== source/ifu_bus_arb.sv ====
/*
 * external instruction memory bus arbiter
 * grants the four-phase mem bus to cache fill or dma read,
 * dma wins a tie, grant held until the cycle closes
 */
`default_nettype none

module ifu_bus_arb import ifu_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   ifu_bus_if.responder fill_bus,   // from icache
   input  logic         dma_req,
   input  word_addr_t   dma_addr,
   output logic         dma_ack,
   output word_t        dma_rdata,
   output logic         mem_req,
   output word_addr_t   mem_addr,
   input  logic         mem_ack,
   input  word_t        mem_rdata
);

   arb_owner_t owner;
   logic       bus_idle;    // mem bus fully quiet
   logic       owner_req;   // req of the current owner
   logic       resp_ack;    // ack toward the owner
   logic       served;      // memory data already returned
   word_t      rdata_q;

   assign bus_idle  = ~mem_req & ~mem_ack;
   assign owner_req = (owner == own_dma) ? dma_req : fill_bus.req;

   assign dma_ack        = (owner == own_dma) & resp_ack;  // ack goes to owner only
   assign fill_bus.ack   = (owner == own_fill) & resp_ack;
   assign dma_rdata      = rdata_q;
   assign fill_bus.rdata = rdata_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         owner    <= own_none;
         mem_req  <= 1'b0;
         resp_ack <= 1'b0;
         served   <= 1'b0;
      end else if (owner == own_none) begin
         if (bus_idle & dma_req) begin              // dma first on a tie
            owner   <= own_dma;
            mem_req <= 1'b1;
         end else if (bus_idle & fill_bus.req) begin
            owner   <= own_fill;
            mem_req <= 1'b1;
         end
      end else begin
         if (mem_req & mem_ack) begin
            mem_req  <= 1'b0;
            resp_ack <= 1'b1;
            served   <= 1'b1;
         end
         if (resp_ack & ~owner_req) resp_ack <= 1'b0;   // owner closed its side
         if (served & ~resp_ack & ~mem_ack) begin       // both sides closed
            owner  <= own_none;
            served <= 1'b0;
         end
      end
   end

   // address and data payload
   always_ff @(posedge clk) begin
      if ((owner == own_none) & bus_idle) mem_addr <= dma_req ? dma_addr : fill_bus.addr;
      if (mem_req & mem_ack) rdata_q <= mem_rdata;
   end

   // no handover in the middle of a memory cycle
   owner_hold_a: assert property (@(posedge clk) disable iff (rst)
      (mem_req || mem_ack) |=> $stable(owner));

endmodule

`default_nettype wire

// ==== source/ifu_fetch_ctl.sv ====
/*
 * fetch control
 * fetch pc register, flush redirect,
 * four-phase fetch sequencing and word hand-off to the aligner
 */
`default_nettype none

module ifu_fetch_ctl import ifu_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         flush,      // redirect to flush_pc
   input  pc_t          flush_pc,
   ifu_bus_if.requester fetch_bus,  // to icache
   ifu_word_if.source   word_link   // to aligner
);

   fetch_state_t state;
   pc_t          fetch_pc;   // next pc to fetch
   pc_t          req_pc;     // pc of the open request
   word_t        word_q;     // fetched word held for the aligner
   logic         bus_req;
   logic         word_req;
   logic         launch;     // start a new fetch this cycle

   assign launch = (state == fc_idle) & ~flush & ~fetch_bus.ack; // prior ack must be low

   assign fetch_bus.req  = bus_req;
   assign fetch_bus.addr = req_pc[31:2]; // word address of the request
   assign word_link.req  = word_req;
   assign word_link.pc   = req_pc;
   assign word_link.word = word_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= fc_idle;
         fetch_pc <= '0;              // fetch starts at pc zero
         bus_req  <= 1'b0;
         word_req <= 1'b0;
      end else begin
         if (flush) fetch_pc <= flush_pc; // redirect in any state
         case (state)
            fc_idle: begin
               if (launch) begin
                  bus_req <= 1'b1;
                  state   <= fc_request;
               end
            end
            fc_request: begin
               if (fetch_bus.ack) begin
                  bus_req <= 1'b0;
                  state   <= flush ? fc_idle : fc_deliver; // flushed word is dropped
               end else if (flush) begin
                  state   <= fc_drain;
               end
            end
            fc_drain: begin
               if (fetch_bus.ack) begin  // finish the stale cycle
                  bus_req <= 1'b0;
                  state   <= fc_idle;
               end
            end
            fc_deliver: begin
               if (flush) begin
                  word_req <= 1'b0;       // aligner never acks in a flush cycle
                  state    <= fc_idle;
               end else if (word_req & word_link.ack) begin
                  word_req <= 1'b0;
                  fetch_pc <= {fetch_pc[31:2] + 30'd1, 1'b0}; // next word, even half
                  state    <= fc_idle;
               end else if (~word_req & ~word_link.ack) begin
                  word_req <= 1'b1;
               end
            end
            default: state <= fc_idle;
         endcase
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (launch) req_pc <= fetch_pc;
      if ((state == fc_request) & fetch_bus.ack) word_q <= fetch_bus.rdata;
   end

   // request address must hold until the responder acks
   addr_stable_a: assert property (@(posedge clk) disable iff (rst)
      (fetch_bus.req && !fetch_bus.ack) |=> $stable(fetch_bus.addr));

endmodule

`default_nettype wire

// ==== source/ifu_icache.sv ====
/*
 * direct-mapped instruction cache, one word per line
 * tag / valid / data arrays, hit lookup, miss fill over fill_bus,
 * whole-cache invalidate on fence_i
 */
`default_nettype none

module ifu_icache import ifu_pkg::*; #(
   parameter int ic_index_bits = 4     // log2 of line count
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         fence_i,       // invalidate all lines
   ifu_bus_if.responder fetch_bus,     // from fetch control
   ifu_bus_if.requester fill_bus       // to bus arbiter
);

   localparam int tag_bits = 30 - ic_index_bits;  // word addr bits above the index
   localparam int lines    = 1 << ic_index_bits;

   // ******************************
   // arrays
   // ******************************
   logic [tag_bits-1:0] tag_mem [lines];
   word_t               data_mem [lines];
   logic [lines-1:0]    valid_q;           // only the valid bits are reset

   fill_state_t              state;
   logic [ic_index_bits-1:0] idx;
   logic [tag_bits-1:0]      tag;
   logic                     hit;
   logic                     ack_q;
   logic                     fill_req_q;
   word_t                    rdata_q;
   logic                     fill_done;     // fill data arriving this cycle

   assign idx = fetch_bus.addr[ic_index_bits+1:2];
   assign tag = fetch_bus.addr[31:ic_index_bits+2];
   assign hit = valid_q[idx] & (tag_mem[idx] == tag);

   assign fill_done = (state == ic_fill_wait) & fill_bus.ack;

   assign fetch_bus.ack   = ack_q;
   assign fetch_bus.rdata = rdata_q;
   assign fill_bus.req    = fill_req_q;
   assign fill_bus.addr   = fetch_bus.addr; // fetch req holds addr through the fill

   // ******************************
   // control
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ic_idle;
         valid_q    <= '0;
         ack_q      <= 1'b0;
         fill_req_q <= 1'b0;
      end else begin
         case (state)
            ic_idle: begin
               if (fence_i) valid_q <= '0;                 // one cycle invalidate
               if (fetch_bus.req & ~ack_q) state <= ic_lookup;
            end
            ic_lookup: begin
               if (hit) begin
                  ack_q <= 1'b1;                           // data ready next cycle
                  state <= ic_respond;
               end else begin
                  state <= ic_fill_req;
               end
            end
            ic_fill_req: begin
               if (~fill_bus.ack) begin                    // previous fill fully closed
                  fill_req_q <= 1'b1;
                  state      <= ic_fill_wait;
               end
            end
            ic_fill_wait: begin
               if (fill_done) begin
                  fill_req_q   <= 1'b0;
                  valid_q[idx] <= 1'b1;
                  ack_q        <= 1'b1;
                  state        <= ic_respond;
               end
            end
            ic_respond: begin
               if (~fetch_bus.req) begin                   // fetch saw ack, close cycle
                  ack_q <= 1'b0;
                  state <= ic_idle;
               end
            end
            default: state <= ic_idle;
         endcase
      end
   end

   // array writes and read data
   always_ff @(posedge clk) begin
      if (fill_done) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= fill_bus.rdata;
         rdata_q       <= fill_bus.rdata;  // forward fill word to fetch
      end else if ((state == ic_lookup) & hit) begin
         rdata_q       <= data_mem[idx];
      end
   end

   // a new fill starts only after the last one has fully closed
   fill_four_phase_a: assert property (@(posedge clk) disable iff (rst)
      $rose(fill_bus.req) |-> !fill_bus.ack);

endmodule

`default_nettype wire

// ==== source/ifu_ifs.sv ====
/*
 * ifu_bus_if  four-phase request link (fetch and fill)
 * ifu_word_if fetched word from fetch control to aligner
 */
`default_nettype none

interface ifu_bus_if import ifu_pkg::*; ();
   logic       req;    // held until ack seen
   word_addr_t addr;   // stable while req high
   logic       ack;    // held until req drops
   word_t      rdata;  // valid while ack high

   modport requester (output req, output addr, input ack, input rdata);
   modport responder (input req, input addr, output ack, output rdata);
endinterface

interface ifu_word_if import ifu_pkg::*; ();
   logic  req;   // word offered
   pc_t   pc;    // pc of the word, odd means skip low half
   word_t word;  // raw fetched word
   logic  ack;   // aligner took the word

   modport source (output req, output pc, output word, input ack);
   modport sink   (input req, input pc, input word, output ack);
endinterface

`default_nettype wire

// ==== source/ifu_pkg.sv ====
/*
 * instruction fetch unit shared definitions
 * address and data width typedefs
 * state enums for fetch control, cache and bus arbiter
 * instruction length helper constants
 */
`default_nettype none

package ifu_pkg;

   // ******************************
   // widths
   // ******************************
   typedef logic [31:1] pc_t;        // halfword granular pc
   typedef logic [31:2] word_addr_t; // word granular address
   typedef logic [31:0] word_t;      // fetch / memory data word
   typedef logic [15:0] half_t;      // one instruction parcel
   typedef logic [31:0] instr_t;     // instruction to decode, rvc zero extended

   // ******************************
   // state machines
   // ******************************
   typedef enum logic [1:0] {
      fc_idle,     // ready to start a fetch
      fc_request,  // fetch_bus cycle open
      fc_deliver,  // word offered to aligner
      fc_drain     // flushed while in flight, wait ack then drop
   } fetch_state_t;

   typedef enum logic [2:0] {
      ic_idle,      // waiting for fetch request
      ic_lookup,    // tag compare
      ic_fill_req,  // raise fill request
      ic_fill_wait, // wait for fill data
      ic_respond    // ack held until fetch drops req
   } fill_state_t;

   typedef enum logic [1:0] {
      own_none,    // bus free
      own_fill,    // cache fill owns the bus
      own_dma      // dma read owns the bus
   } arb_owner_t;

   // ******************************
   // instruction length
   // ******************************
   localparam logic [1:0] length_code_full = 2'b11; // low bits of a 32-bit parcel
   localparam pc_t pc_step_half = 31'd1;            // advance for a 16-bit instr
   localparam pc_t pc_step_full = 31'd2;            // advance for a 32-bit instr

endpackage

`default_nettype wire

// ==== source/ifu_top.sv ====
/*
 * instruction fetch unit top level
 * fetch control, icache, bus arbiter and aligner
 */
`default_nettype none

module ifu_top import ifu_pkg::*; #(
   parameter int ic_index_bits = 4        // icache lines = 2**ic_index_bits
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,              // redirect fetch
   input  pc_t        flush_pc,
   input  logic       fence_i,            // invalidate icache
   // external instruction memory
   output logic       mem_req,
   output word_addr_t mem_addr,
   input  logic       mem_ack,
   input  word_t      mem_rdata,
   // dma read port
   input  logic       dma_req,
   input  word_addr_t dma_addr,
   output logic       dma_ack,
   output word_t      dma_rdata,
   // to decode
   output logic       instr_valid,
   output instr_t     instr,
   output pc_t        instr_pc,
   output logic       instr_pc4,
   input  logic       instr_ready
);

   ifu_bus_if  fetch_bus ();   // fetch ctl -> icache
   ifu_bus_if  fill_bus ();    // icache -> arbiter
   ifu_word_if word_link ();   // fetch ctl -> aligner

   ifu_fetch_ctl fetch_ctl (.clk, .rst, .flush, .flush_pc, .fetch_bus, .word_link);

   ifu_icache #(.ic_index_bits(ic_index_bits)) icache (
      .clk, .rst, .fence_i, .fetch_bus, .fill_bus
   );

   ifu_bus_arb bus_arb (
      .clk, .rst, .fill_bus,
      .dma_req, .dma_addr, .dma_ack, .dma_rdata,
      .mem_req, .mem_addr, .mem_ack, .mem_rdata
   );

   ifu_aligner aligner (
      .clk, .rst, .flush, .instr_ready, .word_link,
      .instr_valid, .instr, .instr_pc, .instr_pc4
   );

endmodule

`default_nettype wire

// ==== testbench/ifu_checker.sv ====
/*
 * scoreboard for the fetch unit
 * reference instruction stream from the memory image,
 * in-order compare of accepted instructions, stall hold check,
 * dma read data compare and error counts
 */
`default_nettype none

module ifu_checker import ifu_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,
   input  pc_t        flush_pc,
   input  logic       instr_valid,
   input  logic       instr_ready,
   input  instr_t     instr,
   input  pc_t        instr_pc,
   input  logic       instr_pc4,
   input  logic       dma_ack,
   input  word_addr_t dma_addr,
   input  word_t      dma_rdata,
   input  word_t      model_mem [1024],   // testbench memory image
   output int         instr_count,
   output int         dma_count,
   output int         instr_errs,
   output int         dma_errs
);
   timeunit 1ns;
   timeprecision 100ps;

   pc_t    exp_pc;        // pc of the next instruction decode should see
   logic   holding;       // last cycle offered without ready
   instr_t held_instr;
   pc_t    held_pc;
   logic   dma_seen;      // dma_ack already high last cycle

   function automatic half_t half_at(input pc_t pc);
      word_t w;
      w = model_mem[pc[11:2]];
      return pc[1] ? w[31:16] : w[15:0];
   endfunction

   // reference: instruction, pc4 and length in halfwords at pc
   function automatic void next_instr(input pc_t pc, output instr_t ins,
                                      output logic pc4, output int len);
      half_t lo;
      half_t hi;
      lo  = half_at(pc);
      hi  = half_at(pc + 31'd1);
      pc4 = (lo[1:0] == 2'b11);
      ins = pc4 ? {hi, lo} : {16'h0000, lo};
      len = pc4 ? 2 : 1;
   endfunction

   function automatic bit values_match(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
      if (got !== exp) $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      return got === exp;
   endfunction

   // ******************************
   // instruction stream
   // ******************************
   always @(negedge clk) begin
      instr_t e_ins;
      logic   e_pc4;
      int     e_len;
      if (rst) begin
         exp_pc      = '0;          // fetch starts at pc zero
         holding     = 1'b0;
         instr_count = 0;
         instr_errs  = 0;
      end else if (flush) begin
         exp_pc  = flush_pc;         // new path starts here
         holding = 1'b0;
      end else begin
         if (holding) begin
            if (!values_match("instr_valid (stalled)", 32'(instr_valid), 32'd1)) instr_errs++;
            if (!values_match("instr (stalled)", instr, held_instr)) instr_errs++;
            if (!values_match("instr_pc (stalled)", {instr_pc, 1'b0}, {held_pc, 1'b0}))
               instr_errs++;
         end
         if (instr_valid && instr_ready) begin
            next_instr(exp_pc, e_ins, e_pc4, e_len);
            if (!values_match("instr_pc", {instr_pc, 1'b0}, {exp_pc, 1'b0})) instr_errs++;
            if (!values_match("instr", instr, e_ins)) instr_errs++;
            if (!values_match("instr_pc4", 32'(instr_pc4), 32'(e_pc4))) instr_errs++;
            exp_pc = exp_pc + pc_t'(e_len);
            instr_count++;
         end
         holding    = instr_valid && !instr_ready;
         held_instr = instr;
         held_pc    = instr_pc;
      end
   end

   // dma data checked once per read, on the rising ack
   always @(negedge clk) begin
      if (rst) begin
         dma_seen  = 1'b0;
         dma_count = 0;
         dma_errs  = 0;
      end else begin
         if (dma_ack && !dma_seen) begin
            if (!values_match("dma_rdata", dma_rdata, model_mem[dma_addr[11:2]])) dma_errs++;
            dma_count++;
         end
         dma_seen = dma_ack;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_ifu.sv ====
/*
 * testbench top for the instruction fetch unit
 * clock, reset, random program memory with four-phase response,
 * dma reads, decode back-pressure, flush and fence_i stimulus
 */
`default_nettype none

module tb_ifu import ifu_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int  wait_instr = 0;       // checker count reaches a target
   localparam int  wait_dma   = 1;       // dma port quiet
   localparam int  wait_stall = 2;       // fetch parked on a full aligner
   localparam pc_t loop_pc    = 31'd21;  // odd halfword revisited for cache hits

   logic       clk;
   logic       rst         = 1'b1;
   logic       flush       = 1'b0;
   pc_t        flush_pc    = '0;
   logic       fence_i     = 1'b0;
   logic       mem_req;
   word_addr_t mem_addr;
   logic       mem_ack     = 1'b0;
   word_t      mem_rdata   = '0;
   logic       dma_req     = 1'b0;
   word_addr_t dma_addr    = '0;
   logic       dma_ack;
   word_t      dma_rdata;
   logic       instr_valid;
   instr_t     instr;
   pc_t        instr_pc;
   logic       instr_pc4;
   logic       instr_ready = 1'b0;

   word_t mem [1024];             // instruction memory model
   int    mem_wait;               // response delay countdown
   logic  stall     = 1'b0;       // hold decode off
   logic  dma_on    = 1'b0;       // allow dma reads
   bit    timed_out = 1'b0;
   int    instr_count;
   int    dma_count;
   int    instr_errs;
   int    dma_errs;

   ifu_top #(.ic_index_bits(4)) dut (
      .clk, .rst, .flush, .flush_pc, .fence_i,
      .mem_req, .mem_addr, .mem_ack, .mem_rdata,
      .dma_req, .dma_addr, .dma_ack, .dma_rdata,
      .instr_valid, .instr, .instr_pc, .instr_pc4, .instr_ready
   );

   ifu_checker scoreboard (
      .clk, .rst, .flush, .flush_pc, .instr_valid, .instr_ready, .instr,
      .instr_pc, .instr_pc4, .dma_ack, .dma_addr, .dma_rdata, .model_mem(mem),
      .instr_count, .dma_count, .instr_errs, .dma_errs
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   // ******************************
   // memory model and port drivers
   // ******************************
   always @(posedge clk) begin
      if (rst) begin
         mem_ack  <= 1'b0;
         mem_wait <= 0;
      end else if (mem_req & ~mem_ack) begin
         if (mem_wait == 1) begin
            mem_ack   <= 1'b1;
            mem_rdata <= mem[mem_addr[11:2]];   // 4 KB image wraps around
         end
         mem_wait <= (mem_wait == 0) ? 1 + $urandom % 5 : mem_wait - 1;
      end else if (~mem_req & mem_ack) begin
         mem_ack <= 1'b0;                       // close four-phase
      end
   end

   always @(posedge clk) instr_ready <= ~stall & ($urandom % 4 != 0);

   always @(posedge clk) begin
      if (dma_req & dma_ack) begin
         dma_req <= 1'b0;                       // data taken
      end else if (dma_on & ~dma_req & ~dma_ack & ($urandom % 8 == 0)) begin
         dma_req  <= 1'b1;
         dma_addr <= word_addr_t'($urandom % 1024);
      end
   end

   // ******************************
   // helpers
   // ******************************
   function automatic void put_half(input int h, input half_t p);
      int w;
      w = (h % 2048) / 2;
      if (h % 2 == 1) mem[w][31:16] = p;
      else mem[w][15:0] = p;
   endfunction

   // random program of mixed 16-bit and 32-bit parcels
   task automatic fill_memory();
      int    h;
      half_t p;
      h = 0;
      while (h < 2048) begin
         p = half_t'($urandom);
         if ($urandom % 2 == 0) begin
            p[1:0] = 2'b11;                      // 32-bit parcel with its upper half next
            put_half(h, p);
            put_half(h + 1, half_t'($urandom));
            h += 2;
         end else begin
            if (p[1:0] == 2'b11) p[1:0] = 2'b10; // keep it compressed
            put_half(h, p);
            h += 1;
         end
      end
   endtask

   // stall also needs decode held off so nothing is taken after the rewrite
   function automatic bit condition_met(input int kind, input int target);
      case (kind)
         wait_instr: return instr_count >= target;
         wait_dma:   return !dma_req && !dma_ack;
         default:    return stall && !instr_ready && dut.fetch_ctl.word_req
                            && !dut.aligner.ack_q && !mem_req && !mem_ack
                            && dut.icache.state == ic_idle;
      endcase
   endfunction

   // poll once per clock until the cycle budget runs out
   task automatic wait_for(input int kind, input int n, input string what);
      int target;
      int t;
      target = instr_count + n;
      t = 0;
      while (!timed_out && !condition_met(kind, target)) begin
         @(posedge clk);
         t++;
         if (t > 20000) begin
            $display("timeout: %s did not happen within 20000 cycles", what);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic redirect(input pc_t pc);
      @(posedge clk);
      flush    <= 1'b1;
      flush_pc <= pc;
      @(posedge clk);
      flush    <= 1'b0;
   endtask

   // ******************************
   // test sequence
   // ******************************
   initial begin
      void'($urandom(32'hdc37));
      fill_memory();
      repeat (4) @(posedge clk);
      rst    <= 1'b0;
      dma_on <= 1'b1;
      wait_for(wait_instr, 300, "in-order stream from pc zero");
      for (int i = 0; i < 16; i++) begin
         redirect(i[0] ? pc_t'($urandom % 2048) : loop_pc);   // loop_pc hits in cache
         wait_for(wait_instr, 12, "instructions after flush");
      end
      repeat (2) begin
         dma_on <= 1'b0;
         stall  <= 1'b1;
         wait_for(wait_dma, 0, "dma port going quiet");
         wait_for(wait_stall, 0, "fetch stall under back-pressure");
         fill_memory();                            // cached words now stale
         fence_i <= 1'b1;
         @(posedge clk);
         fence_i <= 1'b0;
         redirect(instr_pc);                       // line of the head is cached
         stall  <= 1'b0;
         dma_on <= 1'b1;
         wait_for(wait_instr, 200, "instructions from rewritten memory");
      end
      $display("checked %0d instructions and %0d dma reads, errors: %0d instr, %0d dma",
               instr_count, dma_count, instr_errs, dma_errs);
      if (dma_count == 0) $display("no dma read completed during the run");
      if (!timed_out && instr_errs == 0 && dma_errs == 0 && dma_count > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
